//--- design/acc_core.sv
/* Accumulator core used as one TMR replica. Data address is the
   zero-extended operand, JMP keeps pc[31:24]. fetch_enable_i is sampled
   only in IDLE and HALTED; drop it after HALT to rearm the core.
   Bus err with rvalid halts the core */
`timescale 1ns/1ns
`default_nettype none

module acc_core (
  input  logic                          clk_i,
  input  logic                          arst_n_i,
  input  logic                          fetch_enable_i,
  input  logic [tmr_pkg::AddrWidth-1:0] boot_addr_i,
  core_bus_if.mgr                       instr_bus,
  core_bus_if.mgr                       data_bus,
  output logic                          core_busy_o
);
  import tmr_pkg::*;

  typedef enum logic [2:0] {
    IDLE,
    FETCH_REQ,
    FETCH_WAIT,
    EXEC,
    MEM_REQ,
    MEM_WAIT,
    HALTED
  } state_e;

  state_e               state_q, state_d;
  logic [AddrWidth-1:0] pc_q, pc_d;
  logic [DataWidth-1:0] acc_q, acc_d;
  logic [DataWidth-1:0] ir_q;
  logic                 ir_load;
  opcode_e              opcode;
  logic [DataWidth-1:0] operand;
  logic [AddrWidth-1:0] pc_next;

  assign opcode  = opcode_e'(ir_q[OperandWidth +: OpcodeWidth]);
  assign operand = DataWidth'(ir_q[OperandWidth-1:0]);
  assign pc_next = pc_q + AddrWidth'(4);

  always_comb begin
    state_d = state_q;
    pc_d    = pc_q;
    acc_d   = acc_q;
    ir_load = 1'b0;
    case (state_q)
      IDLE: begin
        if (fetch_enable_i) begin
          pc_d    = boot_addr_i;
          state_d = FETCH_REQ;
        end
      end
      FETCH_REQ: begin
        if (instr_bus.gnt) state_d = FETCH_WAIT;
      end
      FETCH_WAIT: begin
        if (instr_bus.rvalid) begin
          ir_load = ~instr_bus.err;
          state_d = instr_bus.err ? HALTED : EXEC;
        end
      end
      EXEC: begin
        case (opcode)
          OP_LDI: begin
            acc_d   = operand;
            pc_d    = pc_next;
            state_d = FETCH_REQ;
          end
          OP_ADDI: begin
            acc_d   = acc_q + operand;
            pc_d    = pc_next;
            state_d = FETCH_REQ;
          end
          OP_JMP: begin
            pc_d    = {pc_q[AddrWidth-1:OperandWidth], ir_q[OperandWidth-1:0]};
            state_d = FETCH_REQ;
          end
          OP_LD, OP_ST: state_d = MEM_REQ;
          default:      state_d = HALTED; // HALT and unknown codes
        endcase
      end
      MEM_REQ: begin
        if (data_bus.gnt) state_d = MEM_WAIT;
      end
      MEM_WAIT: begin
        if (data_bus.rvalid) begin
          if (data_bus.err) begin
            state_d = HALTED;
          end else begin
            if (opcode == OP_LD) acc_d = data_bus.rdata;
            pc_d    = pc_next;
            state_d = FETCH_REQ;
          end
        end
      end
      HALTED: begin
        if (!fetch_enable_i) state_d = IDLE;
      end
      default: state_d = HALTED;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= IDLE;
      pc_q    <= '0;
      acc_q   <= '0;
    end else begin
      state_q <= state_d;
      pc_q    <= pc_d;
      acc_q   <= acc_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (ir_load) ir_q <= instr_bus.rdata;
  end

  assign instr_bus.req   = (state_q == FETCH_REQ);
  assign instr_bus.addr  = pc_q;
  assign instr_bus.we    = 1'b0;
  assign instr_bus.be    = '1;
  assign instr_bus.wdata = '0;

  assign data_bus.req   = (state_q == MEM_REQ);
  assign data_bus.addr  = AddrWidth'(ir_q[OperandWidth-1:0]);
  assign data_bus.we    = (opcode == OP_ST);
  assign data_bus.be    = '1;
  assign data_bus.wdata = acc_q;

  assign core_busy_o = (state_q != IDLE) && (state_q != HALTED);

  // Requests hold until granted
  a_instr_hold : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    instr_bus.req && !instr_bus.gnt |=> instr_bus.req && $stable(instr_bus.addr))
    else $error("instr request dropped or changed before gnt");
  a_data_hold : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    data_bus.req && !data_bus.gnt |=> data_bus.req &&
      $stable({data_bus.addr, data_bus.we, data_bus.be, data_bus.wdata}))
    else $error("data request dropped or changed before gnt");

  // Response only for the granted transfer
  a_instr_rvalid : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    instr_bus.rvalid |-> state_q == FETCH_WAIT)
    else $error("instr rvalid without outstanding fetch");
  a_data_rvalid : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    data_bus.rvalid |-> state_q == MEM_WAIT)
    else $error("data rvalid without outstanding access");

endmodule

`default_nettype wire

//--- design/core_bus_if.sv
/* Request/grant/valid memory bus of one replica. At most one outstanding
   request, rvalid comes one or more cycles after gnt. Writes get an rvalid
   without data */
`timescale 1ns/1ns
`default_nettype none

interface core_bus_if;
  import tmr_pkg::*;

  // Request, held stable until gnt
  logic                 req;
  logic [AddrWidth-1:0] addr;
  logic                 we;
  logic [BeWidth-1:0]   be;
  logic [DataWidth-1:0] wdata;

  // Response
  logic                 gnt;
  logic                 rvalid;
  logic [DataWidth-1:0] rdata;
  logic                 err;   // Only meaningful with rvalid

  modport mgr (
    output req, addr, we, be, wdata,
    input  gnt, rvalid, rdata, err
  );

  modport sub (
    input  req, addr, we, be, wdata,
    output gnt, rvalid, rdata, err
  );

endinterface

`default_nettype wire

//--- design/core_wrap.sv
/* TMR subsystem top: three lockstep accumulator replicas, a majority
   voter on both buses and an APB control block. Boot address low byte
   is ignored. Bus responses go unchanged to all replicas */
`timescale 1ns/1ns
`default_nettype none

module core_wrap #(
  parameter int unsigned ErrCntWidth = tmr_pkg::DefaultErrCntWidth
) (
  input  logic                             clk_i,
  input  logic                             arst_n_i,
  input  logic                             fetch_enable_i,
  input  logic [tmr_pkg::AddrWidth-1:0]    boot_addr_i,

  input  logic                             instr_gnt_i,
  input  logic                             instr_rvalid_i,
  input  logic [tmr_pkg::DataWidth-1:0]    instr_rdata_i,
  input  logic                             instr_err_i,
  output logic                             instr_req_o,
  output logic [tmr_pkg::AddrWidth-1:0]    instr_addr_o,

  input  logic                             data_gnt_i,
  input  logic                             data_rvalid_i,
  input  logic [tmr_pkg::DataWidth-1:0]    data_rdata_i,
  input  logic                             data_err_i,
  output logic                             data_req_o,
  output logic                             data_we_o,
  output logic [tmr_pkg::BeWidth-1:0]      data_be_o,
  output logic [tmr_pkg::AddrWidth-1:0]    data_addr_o,
  output logic [tmr_pkg::DataWidth-1:0]    data_wdata_o,

  output logic                             core_busy_o,

  input  logic                             psel_i,
  input  logic                             penable_i,
  input  logic                             pwrite_i,
  input  logic [tmr_pkg::ApbAddrWidth-1:0] paddr_i,
  input  logic [tmr_pkg::DataWidth-1:0]    pwdata_i,
  output logic [tmr_pkg::DataWidth-1:0]    prdata_o,
  output logic                             pready_o,
  output logic                             pslverr_o
);
  import tmr_pkg::*;

  logic [AddrWidth-1:0]   boot_addr;
  logic [NumReplicas-1:0] busy;
  logic [NumReplicas-1:0] mismatch;
  logic                   inject_valid;
  logic                   inject_done;
  logic [InjSelWidth-1:0] inject_sel;

  core_bus_if instr_bus [NumReplicas] ();
  core_bus_if data_bus  [NumReplicas] ();

  assign boot_addr = boot_addr_i & BootAlignMask;

  for (genvar i = 0; i < NumReplicas; i++) begin : gen_cores
    // Same responses to every replica
    assign instr_bus[i].gnt    = instr_gnt_i;
    assign instr_bus[i].rvalid = instr_rvalid_i;
    assign instr_bus[i].rdata  = instr_rdata_i;
    assign instr_bus[i].err    = instr_err_i;
    assign data_bus[i].gnt     = data_gnt_i;
    assign data_bus[i].rvalid  = data_rvalid_i;
    assign data_bus[i].rdata   = data_rdata_i;
    assign data_bus[i].err     = data_err_i;

    acc_core i_acc_core_tmr_part (
      .clk_i          (clk_i),
      .arst_n_i       (arst_n_i),
      .fetch_enable_i (fetch_enable_i),
      .boot_addr_i    (boot_addr),
      .instr_bus      (instr_bus[i]),
      .data_bus       (data_bus[i]),
      .core_busy_o    (busy[i])
    );
  end

  tmr_voter i_tmr_voter (
    .clk_i, .arst_n_i,
    .instr_bus_i    (instr_bus),
    .data_bus_i     (data_bus),
    .busy_i         (busy),
    .data_gnt_i, .instr_req_o, .instr_addr_o,
    .data_req_o, .data_we_o, .data_be_o, .data_addr_o, .data_wdata_o,
    .core_busy_o,
    .inject_valid_i (inject_valid),
    .inject_sel_i   (inject_sel),
    .mismatch_o     (mismatch),
    .inject_done_o  (inject_done)
  );

  hmr_ctrl_regs #(
    .ErrCntWidth (ErrCntWidth)
  ) i_hmr_ctrl_regs (
    .clk_i, .arst_n_i,
    .psel_i, .penable_i, .pwrite_i, .paddr_i, .pwdata_i,
    .prdata_o, .pready_o, .pslverr_o,
    .mismatch_i     (mismatch),
    .inject_done_i  (inject_done),
    .inject_valid_o (inject_valid),
    .inject_sel_o   (inject_sel)
  );

endmodule

`default_nettype wire

//--- design/hmr_ctrl_regs.sv
/* APB register block of the TMR unit, no wait states.
   ErrCntWidth must lie between 4 and 32. Only offsets 0x0, 0x4 and 0x8
   decode, anything else answers with pslverr */
`timescale 1ns/1ns
`default_nettype none

module hmr_ctrl_regs #(
  parameter int unsigned ErrCntWidth = tmr_pkg::DefaultErrCntWidth
) (
  input  logic                            clk_i,
  input  logic                            arst_n_i,
  input  logic                            psel_i,
  input  logic                            penable_i,
  input  logic                            pwrite_i,
  input  logic [tmr_pkg::ApbAddrWidth-1:0] paddr_i,
  input  logic [tmr_pkg::DataWidth-1:0]   pwdata_i,
  output logic [tmr_pkg::DataWidth-1:0]   prdata_o,
  output logic                            pready_o,
  output logic                            pslverr_o,
  input  logic [tmr_pkg::NumReplicas-1:0] mismatch_i,
  input  logic                            inject_done_i,
  output logic                            inject_valid_o,
  output logic [tmr_pkg::InjSelWidth-1:0] inject_sel_o
);
  import tmr_pkg::*;

  logic                   access;
  logic                   wr;
  logic                   hit_status;
  logic                   hit_errcnt;
  logic                   hit_inject;
  logic                   bad_cnt_wr;
  logic                   any_mismatch;
  logic [NumReplicas-1:0] status_q;
  logic [NumReplicas-1:0] status_clr;
  logic [ErrCntWidth-1:0] err_cnt_q;
  logic [InjSelWidth-1:0] sel_q;
  logic                   arm_q;

  assign access     = psel_i & penable_i;
  assign wr         = access & pwrite_i;
  assign hit_status = (paddr_i == RegStatus);
  assign hit_errcnt = (paddr_i == RegErrCnt);
  assign hit_inject = (paddr_i == RegInject);
  assign bad_cnt_wr = hit_errcnt & pwrite_i & (pwdata_i != '0);

  assign pready_o  = access;
  assign pslverr_o = access & ((~hit_status & ~hit_errcnt & ~hit_inject) | bad_cnt_wr);

  assign any_mismatch = |mismatch_i;
  assign status_clr   = (wr && hit_status) ? pwdata_i[NumReplicas-1:0] : '0;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      status_q <= '0;
    end else begin
      status_q <= (status_q & ~status_clr) | mismatch_i; // Set beats clear
    end
  end

  // Saturating count of cycles with any disagreement
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      err_cnt_q <= '0;
    end else if (wr && hit_errcnt && !bad_cnt_wr) begin
      err_cnt_q <= ErrCntWidth'(any_mismatch);
    end else if (any_mismatch && err_cnt_q != '1) begin
      err_cnt_q <= err_cnt_q + 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      sel_q <= '0;
      arm_q <= 1'b0;
    end else if (wr && hit_inject) begin
      sel_q <= pwdata_i[InjSelWidth-1:0];
      arm_q <= pwdata_i[InjArmBit];
    end else if (inject_done_i) begin
      arm_q <= 1'b0; // One shot
    end
  end

  assign inject_valid_o = arm_q;
  assign inject_sel_o   = sel_q;

  always_comb begin
    prdata_o = '0;
    if (hit_status) begin
      prdata_o[NumReplicas-1:0] = status_q;
    end else if (hit_errcnt) begin
      prdata_o[ErrCntWidth-1:0] = err_cnt_q;
    end else if (hit_inject) begin
      prdata_o[InjArmBit]         = arm_q;
      prdata_o[InjSelWidth-1:0]   = sel_q;
    end
  end

  a_apb_setup : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    penable_i |-> $past(psel_i && !penable_i))
    else $error("APB access phase without setup phase");

  // Voter may only corrupt data while the self-test is armed
  a_inject_armed : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    inject_done_i |-> arm_q)
    else $error("inject_done while self-test not armed");

endmodule

`default_nettype wire

//--- design/tmr_pkg.sv
/* Shared constants and encodings of the TMR accumulator subsystem.
   Instruction word holds the opcode in [31:24] and the operand in [23:0].
   NumReplicas is fixed at three, the voter is a 2-of-3 majority */
`default_nettype none

package tmr_pkg;

  localparam int unsigned AddrWidth    = 32;
  localparam int unsigned DataWidth    = 32;
  localparam int unsigned BeWidth      = DataWidth / 8;
  localparam int unsigned OperandWidth = 24;
  localparam int unsigned OpcodeWidth  = DataWidth - OperandWidth;

  localparam int unsigned NumReplicas = 3;

  // Default width of the mismatch cycle counter, 4 to 32 is legal
  localparam int unsigned DefaultErrCntWidth = 16;

  localparam int unsigned ApbAddrWidth = 12;

  // Zero is HALT so that erased memory stops the core
  typedef enum logic [OpcodeWidth-1:0] {
    OP_HALT = 8'h00,
    OP_LDI  = 8'h01, // acc = zext(operand)
    OP_ADDI = 8'h02, // acc += zext(operand)
    OP_LD   = 8'h03, // acc = mem[zext(operand)]
    OP_ST   = 8'h04, // mem[zext(operand)] = acc
    OP_JMP  = 8'h05  // pc = {pc[31:24], operand}
  } opcode_e;

  // Low byte of the boot address is dropped
  localparam logic [AddrWidth-1:0] BootAlignMask = 32'hFFFF_FF00;

  // Register map of the redundancy control block
  localparam logic [ApbAddrWidth-1:0] RegStatus = 12'h000;
  localparam logic [ApbAddrWidth-1:0] RegErrCnt = 12'h004;
  localparam logic [ApbAddrWidth-1:0] RegInject = 12'h008;

  // RegInject fields
  localparam int unsigned InjSelWidth = 2;
  localparam int unsigned InjArmBit   = 8;

endpackage

`default_nettype wire

//--- design/tmr_voter.sv
/* Combinational 2-of-3 voter over both replica buses and busy flags.
   Data payload is compared only in a granted data cycle. The self-test
   flips wdata bit 0 of the selected replica in a granted store cycle */
`timescale 1ns/1ns
`default_nettype none

module tmr_voter (
  input  logic                                  clk_i,
  input  logic                                  arst_n_i,
  core_bus_if.mgr                               instr_bus_i [tmr_pkg::NumReplicas],
  core_bus_if.mgr                               data_bus_i [tmr_pkg::NumReplicas],
  input  logic [tmr_pkg::NumReplicas-1:0]       busy_i,
  input  logic                                  data_gnt_i,
  input  logic                                  inject_valid_i,
  input  logic [tmr_pkg::InjSelWidth-1:0]       inject_sel_i,
  output logic                                  instr_req_o,
  output logic [tmr_pkg::AddrWidth-1:0]         instr_addr_o,
  output logic                                  data_req_o,
  output logic                                  data_we_o,
  output logic [tmr_pkg::BeWidth-1:0]           data_be_o,
  output logic [tmr_pkg::AddrWidth-1:0]         data_addr_o,
  output logic [tmr_pkg::DataWidth-1:0]         data_wdata_o,
  output logic                                  core_busy_o,
  output logic [tmr_pkg::NumReplicas-1:0]       mismatch_o,
  output logic                                  inject_done_o
);
  import tmr_pkg::*;

  // Always compared: instr req/addr, data req, busy
  localparam int unsigned CtrlWidth    = 1 + AddrWidth + 1 + 1;
  // Compared in granted data cycles: we, be, addr, wdata
  localparam int unsigned PayloadWidth = 1 + BeWidth + AddrWidth + DataWidth;
  localparam int unsigned VecWidth     = CtrlWidth + PayloadWidth;

  logic [VecWidth-1:0]    vec [NumReplicas];
  logic [VecWidth-1:0]    vote;
  logic [VecWidth-1:0]    cmp_mask;
  logic [NumReplicas-1:0] dreq;
  logic [NumReplicas-1:0] dwe;
  logic [NumReplicas-1:0] flip;
  logic                   dreq_vote;
  logic                   payload_en;
  logic                   inject_ok;

  // Voted data req from raw replica bits, kept apart from the flipped vector
  assign dreq_vote  = (dreq[0] & dreq[1]) | (dreq[0] & dreq[2]) | (dreq[1] & dreq[2]);
  assign payload_en = dreq_vote & data_gnt_i;
  assign inject_ok  = inject_valid_i & payload_en;

  for (genvar r = 0; r < NumReplicas; r++) begin : gen_replica
    assign dreq[r] = data_bus_i[r].req;
    assign dwe[r]  = data_bus_i[r].we;
    assign flip[r] = inject_ok && (inject_sel_i == InjSelWidth'(r)) && dwe[r];

    assign vec[r] = {instr_bus_i[r].req, instr_bus_i[r].addr,
                     data_bus_i[r].req, busy_i[r],
                     data_bus_i[r].we, data_bus_i[r].be, data_bus_i[r].addr,
                     data_bus_i[r].wdata[DataWidth-1:1],
                     data_bus_i[r].wdata[0] ^ flip[r]};

    assign mismatch_o[r] = |((vec[r] ^ vote) & cmp_mask);
  end

  assign vote     = (vec[0] & vec[1]) | (vec[0] & vec[2]) | (vec[1] & vec[2]);
  assign cmp_mask = {{CtrlWidth{1'b1}}, {PayloadWidth{payload_en}}};

  assign {instr_req_o, instr_addr_o, data_req_o, core_busy_o,
          data_we_o, data_be_o, data_addr_o, data_wdata_o} = vote;

  assign inject_done_o = |flip;

  // Two or more outliers means the vote itself may be wrong
  a_single_fault : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    $countones(mismatch_o) <= 1)
    else $warning("double fault, replicas %b disagree with the vote", mismatch_o);

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# Builds the tmr_core testbench with Verilator, runs it and checks the log
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert -Wno-fatal -f tmr_core.f \
  --top-module tb_core_wrap -Mdir obj_dir -o sim_tb_core_wrap > build.log 2>&1 \
  || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/sim_tb_core_wrap > sim.log 2>&1
cat sim.log
grep -q "TESTS PASSED" sim.log && exit 0 || exit 1

//--- tmr_core.f
design/tmr_pkg.sv
design/core_bus_if.sv
design/acc_core.sv
design/tmr_voter.sv
design/hmr_ctrl_regs.sv
design/core_wrap.sv
verif/tb_clkgen.sv
verif/tb_core_wrap.sv

//--- verif/tb_clkgen.sv
/* Free-running testbench clock and active-low reset.
   Reset is released 1 ns after the ResetCycles-th rising edge */
`timescale 1ns/1ns
`default_nettype none

module tb_clkgen #(
  parameter int unsigned Period      = 8,
  parameter int unsigned ResetCycles = 4
) (
  output logic clk_o,
  output logic arst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(Period / 2) clk_o = ~clk_o;
  end

  initial begin
    arst_n_o = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    #1 arst_n_o = 1'b1;
  end

endmodule

`default_nettype wire

//--- verif/tb_core_wrap.sv
/* Directed testbench of the TMR subsystem with a behavioral memory.
   Program memory covers 0x1234_5600..0x1234_56FF, data memory 0x000..0x3FF.
   Random bus delays use $urandom with a fixed seed */
`timescale 1ns/1ns
`default_nettype none

module tb_core_wrap;
  import tmr_pkg::*;

  localparam logic [31:0] BootAddr      = 32'h1234_5678;
  localparam logic [31:0] ImemBase      = 32'h1234_5600;
  localparam int unsigned ImemWords     = 64;
  localparam int unsigned DmemWords     = 256;
  localparam int unsigned NumTests      = 5;
  localparam int unsigned CyclesPerTest = 2000;
  localparam int unsigned ClkPeriod     = 8;

  logic        clk;
  logic        arst_n;
  logic        fetch_enable;
  logic [31:0] boot_addr;
  logic        instr_gnt, instr_rvalid, instr_err, instr_req_o;
  logic [31:0] instr_rdata, instr_addr_o;
  logic        data_gnt, data_rvalid, data_err, data_req_o, data_we_o;
  logic [31:0] data_rdata, data_addr_o, data_wdata_o;
  logic [3:0]  data_be_o;
  logic        core_busy_o;
  logic        psel, penable, pwrite, pready_o, pslverr_o;
  logic [11:0] paddr;
  logic [31:0] pwdata, prdata_o;

  logic [31:0] imem [ImemWords];
  logic [31:0] dmem [DmemWords];
  logic [31:0] exp_mem [DmemWords];
  int unsigned store_cnt [DmemWords];
  int unsigned exp_cnt [DmemWords];
  bit          rand_delays;

  tb_clkgen #(.Period(ClkPeriod), .ResetCycles(4)) i_clkgen (.clk_o(clk), .arst_n_o(arst_n));

  core_wrap dut0 (
    .clk_i (clk), .arst_n_i (arst_n), .fetch_enable_i (fetch_enable), .boot_addr_i (boot_addr),
    .instr_gnt_i (instr_gnt), .instr_rvalid_i (instr_rvalid), .instr_rdata_i (instr_rdata),
    .instr_err_i (instr_err), .instr_req_o (instr_req_o), .instr_addr_o (instr_addr_o),
    .data_gnt_i (data_gnt), .data_rvalid_i (data_rvalid), .data_rdata_i (data_rdata),
    .data_err_i (data_err), .data_req_o (data_req_o), .data_we_o (data_we_o),
    .data_be_o (data_be_o), .data_addr_o (data_addr_o), .data_wdata_o (data_wdata_o),
    .core_busy_o (core_busy_o),
    .psel_i (psel), .penable_i (penable), .pwrite_i (pwrite), .paddr_i (paddr),
    .pwdata_i (pwdata), .prdata_o (prdata_o), .pready_o (pready_o), .pslverr_o (pslverr_o)
  );

  task automatic stop_with_error(input string what);
    $display("%s", what);
    $display("TESTS FAILED");
    $fatal(1);
  endtask

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp)
      else stop_with_error($sformatf("MISMATCH %s got 0x%08h expected 0x%08h", name, got, exp));
  endtask

  // Every wait ends 1 ns after a rising edge
  task automatic wait_cycles(input int unsigned n);
    repeat (n) begin
      @(posedge clk);
      #1;
    end
  endtask

  function automatic int unsigned pick_delay(input int unsigned lo, input int unsigned hi);
    if (!rand_delays) return lo;
    return lo + ($urandom % (hi - lo + 1));
  endfunction

  function automatic logic [31:0] dmem_fill(input int unsigned idx);
    logic [31:0] addr;
    addr = idx * 4;
    return 32'hDA7A_0000 ^ (addr << 12) ^ addr;
  endfunction

  function automatic logic [31:0] insn(input opcode_e op, input logic [23:0] operand);
    return {op, operand};
  endfunction

  task automatic load_program();
    for (int i = 0; i < ImemWords; i++) begin
      imem[i] = {8'h00, ImemBase[23:0] + 24'(i * 4)}; // HALT, operand tags the address
    end
    imem[0] = insn(OP_LDI, 24'h000123);
    imem[1] = insn(OP_ADDI, 24'h000F00);
    imem[2] = insn(OP_ST, 24'h000100);
    imem[3] = insn(OP_LD, 24'h000104);
    imem[4] = insn(OP_ADDI, 24'h000011);
    imem[5] = insn(OP_ST, 24'h000108);
    imem[6] = insn(OP_JMP, 24'h345620);
    imem[7] = insn(OP_ST, 24'h00010C); // Skipped by the jump
    imem[8] = insn(OP_HALT, 24'h000000);
  endtask

  task automatic clear_data_memory();
    for (int i = 0; i < DmemWords; i++) begin
      dmem[i] = dmem_fill(i);
      store_cnt[i] = 0;
    end
  endtask

  // Reference interpreter of the opcode rules
  task automatic model_program();
    logic [31:0] pc;
    logic [31:0] acc;
    logic [31:0] word;
    logic [31:0] operand;
    bit          running;
    int unsigned steps;
    pc = BootAddr & 32'hFFFF_FF00;
    acc = '0;
    running = 1'b1;
    steps = 0;
    for (int i = 0; i < DmemWords; i++) begin
      exp_mem[i] = dmem_fill(i);
      exp_cnt[i] = 0;
    end
    while (running && steps < 1000) begin
      word = imem[pc[7:2]];
      operand = {8'h00, word[23:0]};
      steps++;
      pc = pc + 32'd4;
      case (word[31:24])
        OP_LDI:  acc = operand;
        OP_ADDI: acc = acc + operand;
        OP_LD:   acc = exp_mem[operand[9:2]];
        OP_ST: begin
          exp_mem[operand[9:2]] = acc;
          exp_cnt[operand[9:2]]++;
        end
        OP_JMP:  pc = {pc[31:24], word[23:0]};
        default: running = 1'b0;
      endcase
    end
  endtask

  initial begin : instr_responder
    logic [31:0] addr;
    forever begin
      wait_cycles(1);
      if (instr_req_o) begin
        wait_cycles(pick_delay(0, 3));
        addr = instr_addr_o;
        assert (addr[31:8] == ImemBase[31:8])
          else stop_with_error("instruction fetch outside the program memory");
        instr_gnt = 1'b1;
        wait_cycles(1);
        instr_gnt = 1'b0;
        wait_cycles(pick_delay(1, 3) - 1);
        instr_rvalid = 1'b1;
        instr_rdata = imem[addr[7:2]];
        wait_cycles(1);
        instr_rvalid = 1'b0;
      end
    end
  end

  initial begin : data_responder
    logic [31:0] addr;
    logic [31:0] wdata;
    logic        we;
    forever begin
      wait_cycles(1);
      if (data_req_o) begin
        wait_cycles(pick_delay(0, 3));
        data_gnt = 1'b1;
        #1;
        addr = data_addr_o;
        we = data_we_o;
        wdata = data_wdata_o; // Voted value in the granted cycle
        assert (addr < DmemWords * 4 && addr[1:0] == 2'b00 && data_be_o == 4'hF)
          else stop_with_error("data access outside the data memory or with partial bytes");
        wait_cycles(1);
        data_gnt = 1'b0;
        if (we) begin
          dmem[addr[9:2]] = wdata;
          store_cnt[addr[9:2]]++;
        end
        wait_cycles(pick_delay(1, 3) - 1);
        data_rvalid = 1'b1;
        data_rdata = we ? '0 : dmem[addr[9:2]];
        wait_cycles(1);
        data_rvalid = 1'b0;
      end
    end
  end

  task automatic apb_access(input logic write, input logic [11:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic slverr);
    psel = 1'b1;
    penable = 1'b0;
    pwrite = write;
    paddr = addr;
    pwdata = wdata;
    wait_cycles(1);
    penable = 1'b1;
    #1;
    check_val("pready_o", 32'(pready_o), 32'd1);
    rdata = prdata_o;
    slverr = pslverr_o;
    wait_cycles(1);
    psel = 1'b0;
    penable = 1'b0;
  endtask

  task automatic write_reg(input logic [11:0] addr, input logic [31:0] data, input logic exp_err);
    logic [31:0] rdata;
    logic        err;
    apb_access(1'b1, addr, data, rdata, err);
    check_val($sformatf("pslverr_o write 0x%03h", addr), 32'(err), 32'(exp_err));
  endtask

  task automatic expect_reg(input logic [11:0] addr, input logic [31:0] exp, input logic exp_err);
    logic [31:0] rdata;
    logic        err;
    apb_access(1'b0, addr, '0, rdata, err);
    check_val($sformatf("pslverr_o read 0x%03h", addr), 32'(err), 32'(exp_err));
    if (!exp_err) check_val($sformatf("prdata_o at 0x%03h", addr), rdata, exp);
  endtask

  task automatic wait_busy(input logic level, input int unsigned limit);
    int unsigned n;
    n = 0;
    while (core_busy_o !== level) begin
      assert (n < limit)
        else stop_with_error($sformatf("core_busy_o stuck, never went to %0d", level));
      wait_cycles(1);
      n++;
    end
  endtask

  task automatic compare_memory();
    for (int i = 0; i < DmemWords; i++) begin
      check_val($sformatf("dmem[0x%03h]", i * 4), dmem[i], exp_mem[i]);
      check_val($sformatf("stores to 0x%03h", i * 4), store_cnt[i], exp_cnt[i]);
    end
  endtask

  task automatic run_program(input bit random_delays);
    rand_delays = random_delays;
    clear_data_memory();
    model_program();
    fetch_enable = 1'b1;
    wait_busy(1'b1, 20);
    check_val("instr_addr_o", instr_addr_o, ImemBase); // First fetch, low byte dropped
    wait_busy(1'b0, CyclesPerTest);
    fetch_enable = 1'b0;
    wait_cycles(2);
    compare_memory();
  endtask

  task automatic check_reset_state();
    check_val("instr_req_o", 32'(instr_req_o), 32'd0);
    check_val("data_req_o", 32'(data_req_o), 32'd0);
    check_val("core_busy_o", 32'(core_busy_o), 32'd0);
    check_val("pready_o", 32'(pready_o), 32'd0);
    check_val("pslverr_o", 32'(pslverr_o), 32'd0);
    expect_reg(RegStatus, 32'd0, 1'b0);
    expect_reg(RegErrCnt, 32'd0, 1'b0);
    expect_reg(RegInject, 32'd0, 1'b0);
  endtask

  task automatic run_basic_program();
    run_program(1'b0);
    expect_reg(RegStatus, 32'd0, 1'b0);
    expect_reg(RegErrCnt, 32'd0, 1'b0);
  endtask

  task automatic run_with_backpressure();
    run_program(1'b1);
    expect_reg(RegStatus, 32'd0, 1'b0);
    expect_reg(RegErrCnt, 32'd0, 1'b0);
  endtask

  task automatic inject_each_replica();
    for (int k = 0; k < 3; k++) begin
      write_reg(RegInject, 32'h100 | k, 1'b0);
      run_program(1'b1);
      expect_reg(RegStatus, 32'd1 << k, 1'b0);
      expect_reg(RegErrCnt, 32'd1, 1'b0); // Single granted store
      expect_reg(RegInject, k, 1'b0);
      write_reg(RegStatus, 32'h7, 1'b0);
      write_reg(RegErrCnt, 32'd0, 1'b0);
      expect_reg(RegStatus, 32'd0, 1'b0);
    end
  endtask

  task automatic exercise_registers();
    write_reg(RegInject, 32'h100, 1'b0);
    run_program(1'b0);
    write_reg(RegInject, 32'h102, 1'b0);
    run_program(1'b0);
    expect_reg(RegStatus, 32'h5, 1'b0);
    expect_reg(RegErrCnt, 32'd2, 1'b0);
    write_reg(RegStatus, 32'h1, 1'b0);
    expect_reg(RegStatus, 32'h4, 1'b0);
    write_reg(RegStatus, 32'h4, 1'b0);
    expect_reg(RegStatus, 32'h0, 1'b0);
    write_reg(RegErrCnt, 32'd5, 1'b1);
    expect_reg(RegErrCnt, 32'd2, 1'b0);
    write_reg(RegErrCnt, 32'd0, 1'b0);
    expect_reg(RegErrCnt, 32'd0, 1'b0);
    expect_reg(12'h00C, 32'd0, 1'b1);
    write_reg(12'h00C, 32'h1, 1'b1);
    // Selection 3 stays armed and never corrupts
    write_reg(RegInject, 32'h103, 1'b0);
    run_program(1'b1);
    expect_reg(RegStatus, 32'd0, 1'b0);
    expect_reg(RegErrCnt, 32'd0, 1'b0);
    expect_reg(RegInject, 32'h103, 1'b0);
    write_reg(RegInject, 32'h0, 1'b0);
  endtask

  initial begin : watchdog
    #(NumTests * CyclesPerTest * ClkPeriod);
    stop_with_error("watchdog timeout, tests did not complete in time");
  end

  initial begin
    void'($urandom(72567));
    fetch_enable = 1'b0;
    boot_addr = BootAddr;
    instr_gnt = 1'b0;
    instr_rvalid = 1'b0;
    instr_rdata = '0;
    instr_err = 1'b0;
    data_gnt = 1'b0;
    data_rvalid = 1'b0;
    data_rdata = '0;
    data_err = 1'b0;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    paddr = '0;
    pwdata = '0;
    rand_delays = 1'b0;
    load_program();
    clear_data_memory();
    wait (arst_n === 1'b1);
    wait_cycles(1);
    check_reset_state();
    run_basic_program();
    run_with_backpressure();
    inject_each_replica();
    exercise_registers();
    $display("TESTS PASSED");
    $finish;
  end

endmodule

`default_nettype wire
